//--- common/video_pkg.sv
// screen timing for a 384x264 raster at the cen6 pixel rate; CHAR_LAT must match the colmix blank delay
package video_pkg;

    // raster counters
    typedef logic [8:0] h_cnt_t;
    typedef logic [8:0] v_cnt_t;

    // horizontal timing, active pixels at h 0..255
    localparam int H_TOTAL   = 384;
    localparam int H_VISIBLE = 256;

    // vertical timing, active lines at v 16..239
    localparam int V_TOTAL   = 264;
    localparam int V_VISIBLE = 224;
    localparam int V_START   = 16;

    // sync pulses, start inclusive and end exclusive
    localparam int HS_START  = 300;
    localparam int HS_END    = 332;
    localparam int VS_START  = 250;
    localparam int VS_END    = 253;

    // char pixel is {palette[1:0], colour[3:0]}
    typedef logic [5:0] char_pxl_t;

    // one colour channel at the video output
    typedef logic [3:0] rgb4_t;

    // pixels from h to the char pixel for screen column h - CHAR_LAT
    localparam int CHAR_LAT  = 7;

endpackage

//--- common/cpu_bus_pkg.sv
// CPU side and graphics ROM widths; the tile map decodes only cpu_addr 0..2047
package cpu_bus_pkg;

    // main CPU address as seen by the video board
    typedef logic [11:0] cpu_addr_t;

    // CPU data bus
    typedef logic [7:0]  byte_t;

    // palette RAM entry, 64 of them
    typedef logic [5:0]  pal_idx_t;

    // char ROM word address, {code[9:0], row[2:0], half}
    typedef logic [13:0] rom_addr_t;

    // char ROM word, 4 pixels of 4 bits, lowest nibble first
    typedef logic [15:0] rom_word_t;

endpackage

//--- hdl/video_timer.sv
// raster counters step only on cen6; blanking and sync change together with h and v, no extra delay
module video_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen6,
    output video_pkg::h_cnt_t h,
    output video_pkg::v_cnt_t v,
    output logic              pre_lhbl,
    output logic              pre_lvbl,
    output logic              hs,
    output logic              vs
);
    import video_pkg::*;

    h_cnt_t h_nx;
    v_cnt_t v_nx;

    // next raster position, v moves at the end of each line
    always_comb begin
        h_nx = h + 1'b1;
        v_nx = v;
        if (h == h_cnt_t'(H_TOTAL - 1)) begin
            h_nx = '0;
            v_nx = (v == v_cnt_t'(V_TOTAL - 1)) ? '0 : v + 1'b1;
        end
    end

    // decode from the next position so flags line up with h and v
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h        <= '0;
            v        <= '0;
            pre_lhbl <= 1'b0;
            pre_lvbl <= 1'b0;
            hs       <= 1'b0;
            vs       <= 1'b0;
        end else if (cen6) begin
            h        <= h_nx;
            v        <= v_nx;
            pre_lhbl <= h_nx < H_VISIBLE;
            pre_lvbl <= (v_nx >= V_START) && (v_nx < V_START + V_VISIBLE);
            hs       <= (h_nx >= HS_START) && (h_nx < HS_END);
            vs       <= (v_nx >= VS_START) && (v_nx < VS_END);
        end
    end

    // the char fetch and blank delay both rely on the raster period
    a_h_range: assert property (
        @(posedge clk) disable iff (!rst_n) h < H_TOTAL
    );

    a_v_range: assert property (
        @(posedge clk) disable iff (!rst_n) v < V_TOTAL
    );

endmodule

//--- char/char_layer.sv
// 32x28 tile map; HOFFSET must be 1..8 and the ROM must raise char_ok within 4 clk of char_addr
module char_layer #(
    parameter int HOFFSET = video_pkg::CHAR_LAT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cen6,
    input  video_pkg::h_cnt_t      h,
    input  video_pkg::v_cnt_t      v,
    input  logic                   flip,
    input  cpu_bus_pkg::cpu_addr_t cpu_addr,
    input  cpu_bus_pkg::byte_t     cpu_dout,
    input  logic                   rnw,
    input  logic                   char_cs,
    output cpu_bus_pkg::byte_t     char_dout,
    output logic                   char_busy,
    output cpu_bus_pkg::rom_addr_t char_addr,
    input  cpu_bus_pkg::rom_word_t char_data,
    input  logic                   char_ok,
    output video_pkg::char_pxl_t   char_pxl
);
    import video_pkg::*;
    import cpu_bus_pkg::*;

    // fetch runs 8 pixels ahead of the pixel it feeds
    localparam int LEAD = 8 - HOFFSET;

    byte_t      code_ram [1024];
    byte_t      attr_ram [1024];

    logic [9:0] fx_raw;
    logic [9:0] fx;
    logic       fx_wrap;
    v_cnt_t     line;
    logic [7:0] yy;
    logic [7:0] mx;
    logic [7:0] my;
    logic [9:0] scan_idx;
    logic       scan_rd;
    logic       scan_q;
    logic       cpu_acc;
    logic       wait_ok;
    byte_t      code_q;
    byte_t      attr_q;
    logic [2:0] row_q;
    logic       half_q;
    logic       flip_q;
    rom_word_t  rom_word;
    rom_word_t  ordered;
    rom_word_t  hold_word;
    rom_word_t  shift_word;
    logic [1:0] hold_pal;
    logic [1:0] shift_pal;

    // screen column being fetched, the first group of a line is fetched on the previous one
    always_comb begin
        fx_raw  = {1'b0, h} + 10'(LEAD);
        fx_wrap = fx_raw >= 10'(H_TOTAL);
        fx      = fx_wrap ? fx_raw - 10'(H_TOTAL) : fx_raw;
        line    = fx_wrap ? v + 1'b1 : v;
        yy      = line[7:0] - 8'(V_START);
        mx      = flip ? ~fx[7:0] : fx[7:0];
        my      = flip ? 8'(V_VISIBLE - 1) - yy : yy;
    end

    // one group of 4 pixels every 8 clk, tile RAM belongs to the scan in phase 0
    assign char_busy = fx[1:0] == 2'd0;
    assign scan_rd   = cen6 && char_busy;
    assign scan_idx  = {my[7:3], mx[7:3]};
    assign cpu_acc   = char_cs && !cpu_addr[11] && !char_busy;

    // flipped tiles show their nibbles right to left
    assign ordered = flip_q ? {rom_word[3:0], rom_word[7:4], rom_word[11:8], rom_word[15:12]}
                            : rom_word;

    always_ff @(posedge clk) begin
        if (cpu_acc && !rnw) begin
            if (cpu_addr[10]) begin
                attr_ram[cpu_addr[9:0]] <= cpu_dout;
            end else begin
                code_ram[cpu_addr[9:0]] <= cpu_dout;
            end
        end
        if (cpu_acc && rnw) begin
            char_dout <= cpu_addr[10] ? attr_ram[cpu_addr[9:0]] : code_ram[cpu_addr[9:0]];
        end
        if (scan_rd) begin
            code_q <= code_ram[scan_idx];
            attr_q <= attr_ram[scan_idx];
            row_q  <= my[2:0];
            half_q <= mx[2];
            flip_q <= flip;
        end
    end

    // ROM request one clk after the map read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_q  <= 1'b0;
            wait_ok <= 1'b0;
        end else begin
            scan_q <= scan_rd;
            if (scan_q) begin
                wait_ok <= 1'b1;
            end else if (char_ok) begin
                wait_ok <= 1'b0;
            end
        end
    end

    // word latch, then hold stage, so the next fetch can land early
    always_ff @(posedge clk) begin
        if (scan_q) begin
            char_addr <= {attr_q[1:0], code_q, row_q, half_q};
        end
        if (wait_ok && char_ok) begin
            rom_word <= char_data;
        end
        if (scan_rd) begin
            hold_word <= ordered;
            hold_pal  <= attr_q[3:2];
        end
    end

    // pixel shifter, reload in phase 3 so column h - HOFFSET comes out next
    always_ff @(posedge clk) begin
        if (cen6) begin
            if (fx[1:0] == 2'd3) begin
                char_pxl   <= {hold_pal, hold_word[3:0]};
                shift_word <= hold_word >> 4;
                shift_pal  <= hold_pal;
            end else begin
                char_pxl   <= {shift_pal, shift_word[3:0]};
                shift_word <= shift_word >> 4;
            end
        end
    end

    // ROM word must be in before the hold stage takes it
    a_rom_deadline: assert property (
        @(posedge clk) disable iff (!rst_n) scan_rd |-> !wait_ok
    );

endmodule

//--- colmix/colmix.sv
// write-only 64-entry palette; blank delay fixed at CHAR_LAT+1 pixels, PALW at most 2
module colmix #(
    parameter int PALW = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen6,
    input  video_pkg::char_pxl_t  char_pxl,
    input  logic                  pre_lhbl,
    input  logic                  pre_lvbl,
    input  cpu_bus_pkg::pal_idx_t cpu_addr,
    input  cpu_bus_pkg::byte_t    cpu_dout,
    input  logic                  rnw,
    input  logic                  redgreen_cs,
    input  logic                  blue_cs,
    output video_pkg::rgb4_t      red,
    output video_pkg::rgb4_t      green,
    output video_pkg::rgb4_t      blue,
    output logic                  lhbl,
    output logic                  lvbl
);
    import video_pkg::*;
    import cpu_bus_pkg::*;

    // char pixel latency plus the lookup register
    localparam int DLY  = CHAR_LAT + 1;
    localparam int IDXW = PALW + 4;

    // entry is {red, green, blue}
    logic [11:0]    pal_ram [64];
    logic [11:0]    pal_rd;
    pal_idx_t       pxl_idx;
    logic [DLY-1:0] hb_sr;
    logic [DLY-1:0] vb_sr;

    assign pxl_idx = pal_idx_t'(char_pxl[IDXW-1:0]);
    assign pal_rd  = pal_ram[pxl_idx];

    // red and green share one byte, blue sits alone in the low nibble
    always_ff @(posedge clk) begin
        if (redgreen_cs && !rnw) begin
            pal_ram[cpu_addr][11:4] <= cpu_dout;
        end
        if (blue_cs && !rnw) begin
            pal_ram[cpu_addr][3:0] <= cpu_dout[3:0];
        end
    end

    // tap DLY-2 is the blank of the pixel being looked up
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hb_sr <= '0;
            vb_sr <= '0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (cen6) begin
            hb_sr <= {hb_sr[DLY-2:0], pre_lhbl};
            vb_sr <= {vb_sr[DLY-2:0], pre_lvbl};
            if (hb_sr[DLY-2] && vb_sr[DLY-2]) begin
                {red, green, blue} <= pal_rd;
            end else begin
                {red, green, blue} <= '0;
            end
        end
    end

    assign lhbl = hb_sr[DLY-1];
    assign lvbl = vb_sr[DLY-1];

    // the address decoder must keep the two palette strobes apart
    a_cs_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(redgreen_cs && blue_cs)
    );

endmodule

//--- hdl/video_top.sv
// char layer video; an HOFFSET other than CHAR_LAT also needs the colmix blank delay moved
module video_top #(
    parameter int HOFFSET = video_pkg::CHAR_LAT,
    parameter int PALW    = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cen6,
    input  logic                   flip,
    // CPU bus
    input  cpu_bus_pkg::cpu_addr_t cpu_addr,
    input  cpu_bus_pkg::byte_t     cpu_dout,
    input  logic                   rnw,
    input  logic                   char_cs,
    output cpu_bus_pkg::byte_t     char_dout,
    output logic                   char_busy,
    input  logic                   redgreen_cs,
    input  logic                   blue_cs,
    // char ROM
    output cpu_bus_pkg::rom_addr_t char_addr,
    input  cpu_bus_pkg::rom_word_t char_data,
    input  logic                   char_ok,
    // video out
    output video_pkg::h_cnt_t      h,
    output video_pkg::v_cnt_t      v,
    output logic                   hs,
    output logic                   vs,
    output logic                   lhbl,
    output logic                   lvbl,
    output video_pkg::rgb4_t       red,
    output video_pkg::rgb4_t       green,
    output video_pkg::rgb4_t       blue
);
    import video_pkg::*;

    char_pxl_t char_pxl;
    logic      pre_lhbl;
    logic      pre_lvbl;

    video_timer u_timer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen6     ( cen6     ),
        .h        ( h        ),
        .v        ( v        ),
        .pre_lhbl ( pre_lhbl ),
        .pre_lvbl ( pre_lvbl ),
        .hs       ( hs       ),
        .vs       ( vs       )
    );

    char_layer #(
        .HOFFSET ( HOFFSET )
    ) u_char (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cen6      ( cen6      ),
        .h         ( h         ),
        .v         ( v         ),
        .flip      ( flip      ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .rnw       ( rnw       ),
        .char_cs   ( char_cs   ),
        .char_dout ( char_dout ),
        .char_busy ( char_busy ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .char_pxl  ( char_pxl  )
    );

    colmix #(
        .PALW ( PALW )
    ) u_colmix (
        .clk         ( clk           ),
        .rst_n       ( rst_n         ),
        .cen6        ( cen6          ),
        .char_pxl    ( char_pxl      ),
        .pre_lhbl    ( pre_lhbl      ),
        .pre_lvbl    ( pre_lvbl      ),
        .cpu_addr    ( cpu_addr[5:0] ),
        .cpu_dout    ( cpu_dout      ),
        .rnw         ( rnw           ),
        .redgreen_cs ( redgreen_cs   ),
        .blue_cs     ( blue_cs       ),
        .red         ( red           ),
        .green       ( green         ),
        .blue        ( blue          ),
        .lhbl        ( lhbl          ),
        .lvbl        ( lvbl          )
    );

endmodule

//--- sim/video_tb.sv
// video_top at default HOFFSET and PALW; ROM latency 1..4 clk; the first mismatch stops the run
module video_tb;
    import video_pkg::*;
    import cpu_bus_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      cen6;
    logic      flip;
    cpu_addr_t cpu_addr;
    byte_t     cpu_dout;
    logic      rnw;
    logic      char_cs;
    logic      redgreen_cs;
    logic      blue_cs;
    rom_word_t char_data;
    logic      char_ok;
    byte_t     char_dout;
    logic      char_busy;
    rom_addr_t char_addr;
    h_cnt_t    h;
    v_cnt_t    v;
    logic      hs;
    logic      vs;
    logic      lhbl;
    logic      lvbl;
    rgb4_t     red;
    rgb4_t     green;
    rgb4_t     blue;

    // copies of what the DUT should hold
    byte_t       code_m [1024];
    byte_t       attr_m [1024];
    rom_word_t   rom_m [16384];
    logic [11:0] pal_m [64];
    logic [11:0] pal_new [64];
    logic [2:0]  lat_m [256];

    // ROM model state
    rom_addr_t   rom_addr_q;
    int          rom_wait;
    logic [7:0]  fetch_n;

    // raster tracking in the compare process
    int   col = 0;
    int   row = 0;
    int   hs_cnt = 0;
    int   frames_done = 0;
    int   vs_checks = 0;
    logic hs_q = 1'b0;
    logic vs_q = 1'b0;
    logic lvbl_q = 1'b0;
    logic vs_seen = 1'b0;
    logic chk_on = 1'b0;

    video_top UUT (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cen6        ( cen6        ),
        .flip        ( flip        ),
        .cpu_addr    ( cpu_addr    ),
        .cpu_dout    ( cpu_dout    ),
        .rnw         ( rnw         ),
        .char_cs     ( char_cs     ),
        .char_dout   ( char_dout   ),
        .char_busy   ( char_busy   ),
        .redgreen_cs ( redgreen_cs ),
        .blue_cs     ( blue_cs     ),
        .char_addr   ( char_addr   ),
        .char_data   ( char_data   ),
        .char_ok     ( char_ok     ),
        .h           ( h           ),
        .v           ( v           ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .lhbl        ( lhbl        ),
        .lvbl        ( lvbl        ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        )
    );

    always #20 clk = ~clk;

    // pixel enable every other clk
    always @(posedge clk) begin
        #2;
        cen6 = ~cen6;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected RGB for screen column x on raster line y
    function automatic logic [11:0] ref_pixel(input int x, input int y, input logic fl);
        logic [7:0]  mx;
        logic [7:0]  my;
        logic [9:0]  idx;
        logic [9:0]  code;
        rom_word_t   word;
        logic [3:0]  colour;
        mx     = fl ? 8'(255 - x) : 8'(x);
        my     = fl ? 8'(V_VISIBLE - 1 - (y - V_START)) : 8'(y - V_START);
        idx    = {my[7:3], mx[7:3]};
        code   = {attr_m[idx][1:0], code_m[idx]};
        word   = rom_m[{code, my[2:0], mx[2]}];
        colour = word[mx[1:0] * 4 +: 4];
        return pal_m[{attr_m[idx][3:2], colour}];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] expected, input logic [31:0] got, input string what);
        if (got !== expected) begin
            $display("ERR %0t: %s expected %h got %h", $time, what, expected, got);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // one tile map access held until char_busy lets it through
    task automatic map_access(input cpu_addr_t addr, input byte_t wdata, input logic rd,
                              output byte_t rdata);
        int cnt;
        cnt = 0;
        @(posedge clk);
        #2;
        cpu_addr = addr;
        cpu_dout = wdata;
        rnw      = rd;
        char_cs  = 1'b1;
        while (char_busy) begin
            @(posedge clk);
            #2;
            cnt++;
            if (cnt > 8) begin
                abort_run("char_busy stayed high for more than 8 clk");
            end
        end
        @(posedge clk);
        #2;
        rdata   = char_dout;
        char_cs = 1'b0;
        rnw     = 1'b1;
    endtask

    task automatic pal_write(input pal_idx_t idx, input logic [11:0] rgb);
        @(posedge clk);
        #2;
        cpu_addr    = cpu_addr_t'(idx);
        cpu_dout    = rgb[11:4];
        rnw         = 1'b0;
        redgreen_cs = 1'b1;
        @(posedge clk);
        #2;
        redgreen_cs = 1'b0;
        blue_cs     = 1'b1;
        cpu_dout    = {4'h0, rgb[3:0]};
        @(posedge clk);
        #2;
        blue_cs    = 1'b0;
        rnw        = 1'b1;
        pal_m[idx] = rgb;
    endtask

    task automatic wait_frames(input int n);
        int target;
        int cnt;
        target = frames_done + n;
        cnt    = 0;
        while (frames_done < target) begin
            @(posedge clk);
            cnt++;
            if (cnt > n * 250000) begin
                abort_run("timed out waiting for the end of a frame");
            end
        end
    endtask

    // ROM drops char_ok on a new address and answers after the table latency
    always @(posedge clk) begin
        #2;
        if (char_addr !== rom_addr_q) begin
            rom_addr_q = char_addr;
            rom_wait   = int'(lat_m[fetch_n]);
            fetch_n    = fetch_n + 1'b1;
            char_ok    = 1'b0;
        end else if (rom_wait != 0) begin
            rom_wait = rom_wait - 1;
            if (rom_wait == 0) begin
                char_data = rom_m[rom_addr_q];
                char_ok   = 1'b1;
            end
        end
    end

    // one sample per pixel while the outputs are stable
    always @(negedge clk) begin
        if (rst_n && cen6) begin
            if (lhbl && lvbl) begin
                if (chk_on) begin
                    check(ref_pixel(col, row + V_START, flip), {red, green, blue},
                          $sformatf("pixel x=%0d y=%0d", col, row + V_START));
                    check(col + CHAR_LAT + 1, h, "h at active pixel");
                    check(row + V_START, v, "v at active pixel");
                end
                col++;
            end else if (col != 0) begin
                check(H_VISIBLE, col, "active pixels per line");
                col = 0;
                row++;
            end
            if (lvbl_q && !lvbl) begin
                check(V_VISIBLE, row, "active lines per frame");
                row = 0;
                frames_done++;
            end
            if (hs && !hs_q) begin
                hs_cnt++;
            end
            if (vs && !vs_q) begin
                if (vs_seen) begin
                    check(V_TOTAL, hs_cnt, "hs pulses per vs");
                    vs_checks++;
                end
                vs_seen = 1'b1;
                hs_cnt  = 0;
            end
            hs_q   = hs;
            vs_q   = vs;
            lvbl_q = lvbl;
        end
    end

    initial begin
        logic [31:0] seed;
        byte_t       rd;
        clk         = 1'b0;
        rst_n       = 1'b0;
        cen6        = 1'b0;
        flip        = 1'b0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        rnw         = 1'b1;
        char_cs     = 1'b0;
        redgreen_cs = 1'b0;
        blue_cs     = 1'b0;
        char_data   = '0;
        char_ok     = 1'b0;
        rom_addr_q  = '0;
        rom_wait    = 0;
        fetch_n     = '0;

        seed = 32'hef92_bfeb;
        for (int i = 0; i < 1024; i++) begin
            seed      = lcg_next(seed);
            code_m[i] = seed[31:24];
            seed      = lcg_next(seed);
            attr_m[i] = seed[31:24];
        end
        for (int i = 0; i < 16384; i++) begin
            seed     = lcg_next(seed);
            rom_m[i] = seed[31:16];
        end
        for (int i = 0; i < 64; i++) begin
            seed       = lcg_next(seed);
            pal_m[i]   = seed[31:20];
            seed       = lcg_next(seed);
            pal_new[i] = seed[31:20];
        end
        for (int i = 0; i < 256; i++) begin
            seed     = lcg_next(seed);
            lat_m[i] = 3'(seed[31:30]) + 3'd1;
        end

        // outputs must be idle while reset is held
        repeat (2) @(posedge clk);
        @(negedge clk);
        check(0, {hs, vs, lhbl, lvbl, char_busy}, "sync, blank and busy in reset");
        check(0, {red, green, blue}, "RGB in reset");
        check(0, {h, v}, "raster counters in reset");
        @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < 64; i++) begin
            pal_write(pal_idx_t'(i), pal_m[i]);
        end
        for (int i = 0; i < 1024; i++) begin
            map_access(cpu_addr_t'(i), code_m[i], 1'b0, rd);
            map_access(cpu_addr_t'(i + 1024), attr_m[i], 1'b0, rd);
        end
        for (int i = 0; i < 1024; i++) begin
            map_access(cpu_addr_t'(i), 8'h00, 1'b1, rd);
            check(code_m[i], rd, "tile code readback");
            map_access(cpu_addr_t'(i + 1024), 8'h00, 1'b1, rd);
            check(attr_m[i], rd, "tile attribute readback");
        end

        // the frame in progress saw the map change so checks start on the next one
        wait_frames(1);
        chk_on = 1'b1;
        wait_frames(1);
        @(posedge clk);
        #2;
        flip = 1'b1;
        wait_frames(1);
        @(posedge clk);
        #2;
        flip = 1'b0;
        for (int i = 0; i < 64; i++) begin
            pal_write(pal_idx_t'(i), pal_new[i]);
        end
        wait_frames(1);
        check(1, 32'(vs_checks >= 2), "at least two vs periods counted");

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- project.f
common/video_pkg.sv
common/cpu_bus_pkg.sv
hdl/video_timer.sv
char/char_layer.sv
colmix/colmix.sv
hdl/video_top.sv
sim/video_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the char layer testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module video_tb \
    -f project.f -o video_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/video_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
